/* src/lane_alu.sv */
`timescale 1ns/1ps
`include "vlane_settings.svh"

module lane_alu
(
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  vlane_pkg::lane_word_u a_i,
   input  vlane_pkg::lane_word_u b_i,
   input  vlane_pkg::sew_e       sew_i,
   input  vlane_pkg::alu_op_e    op_i,
   input  logic                  valid_i,
   output vlane_pkg::lane_word_u res_o,
   output vlane_pkg::sew_e       sew_o,
   output logic                  res_valid_o
);

   logic [`ELEM_BYTES-1:0][7:0] elem_mask;
   logic [`ELEM_BYTES*8-1:0]    a_m;
   logic [`ELEM_BYTES*8-1:0]    b_m;
   logic [`ELEM_BYTES*8-1:0]    res_d;

   //////////////////////////////
   // Element width mask

   always_comb
   begin
      for (int b = 0; b < `ELEM_BYTES; b++)
      begin
         if (b <= vlane_pkg::grp_mask(sew_i))
            elem_mask[b] = 8'hff;
         else
            elem_mask[b] = 8'h00;
      end
   end

   assign a_m = a_i.word & elem_mask;
   assign b_m = b_i.word & elem_mask;

   //////////////////////////////
   // Operations, all unsigned

   always_comb
   begin
      case (op_i)
         vlane_pkg::ALU_ADD:  res_d = a_m + b_m;
         vlane_pkg::ALU_SUB:  res_d = a_m - b_m;  // Borrow lands above SEW, masked off
         vlane_pkg::ALU_AND:  res_d = a_m & b_m;
         vlane_pkg::ALU_OR:   res_d = a_m | b_m;
         vlane_pkg::ALU_XOR:  res_d = a_m ^ b_m;
         vlane_pkg::ALU_MINU: res_d = (a_m < b_m) ? a_m : b_m;
         vlane_pkg::ALU_MAXU: res_d = (a_m > b_m) ? a_m : b_m;
         default:             res_d = '0;
      endcase
   end

   //////////////////////////////
   // Output register

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         res_valid_o <= 1'b0;
      else
         res_valid_o <= valid_i;
   end

   // Sew travels with the result for the scatter stage
   always_ff @(posedge clk_i)
   begin
      if (valid_i)
      begin
         res_o.word <= res_d & elem_mask;
         sew_o      <= sew_i;
      end
   end

   // Issue stage only hands over decoded opcodes
   assert property (@(posedge clk_i) disable iff (!rst_i)
      valid_i |-> op_i != vlane_pkg::ALU_RSVD);

endmodule

/* src/operand_gather.sv */
`timescale 1ns/1ps
`include "vlane_settings.svh"

module operand_gather
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 valid_i,
   input  vlane_pkg::alu_cmd_t  cmd_i,
   input  vlane_pkg::lane_vec_t vs1_i,
   input  vlane_pkg::lane_vec_t vs2_i,
   output vlane_pkg::lane_vec_t op_a_o,
   output vlane_pkg::lane_vec_t op_b_o,
   output vlane_pkg::sew_e      sew_o,
   output vlane_pkg::alu_op_e   op_o,
   output logic                 op_valid_o
);

   //////////////////////////////
   // Issue register

   logic                 valid_q;
   vlane_pkg::alu_cmd_t  cmd_q;
   vlane_pkg::lane_vec_t vs1_q;
   vlane_pkg::lane_vec_t vs2_q;
   logic [`ELEM_BYTES*8-1:0] imm_ext;

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         valid_q <= 1'b0;
      else
         valid_q <= valid_i;
   end

   // Operands arrive together with the command
   always_ff @(posedge clk_i)
   begin
      if (valid_i)
      begin
         cmd_q <= cmd_i;
         vs1_q <= vs1_i;
         vs2_q <= vs2_i;
      end
   end

   //////////////////////////////
   // Cross-lane regrouping

   // ALU base+k gets element k of its group
   // Element byte j comes from byte k of lane base+j
   function automatic vlane_pkg::lane_vec_t regroup(input vlane_pkg::lane_vec_t v,
                                                    input vlane_pkg::sew_e sew);
      vlane_pkg::lane_vec_t r;
      int                   msk;
      r   = '0;
      msk = vlane_pkg::grp_mask(sew);
      for (int l = 0; l < `VLANE_NUM; l++)
      begin
         for (int j = 0; j < `ELEM_BYTES; j++)
         begin
            if (j <= msk)  // Upper bytes stay zero
               r[l].bytes[j] = v[(l & ~msk) + j].bytes[l & msk];
         end
      end
      return r;
   endfunction

   assign op_a_o = regroup(vs1_q, cmd_q.sew);

   // Immediate widened to a full word, ALU trims it to SEW
   assign imm_ext = {{(`ELEM_BYTES*8-`IMM_W){cmd_q.imm[`IMM_W-1]}}, cmd_q.imm};

   //////////////////////////////
   // Operand b select

   always_comb
   begin
      case (cmd_q.op2_src)
         vlane_pkg::OP2_VEC:    op_b_o = regroup(vs2_q, cmd_q.sew);
         vlane_pkg::OP2_SCALAR: op_b_o = {`VLANE_NUM{cmd_q.scalar}};  // Same word to every ALU
         vlane_pkg::OP2_IMM:    op_b_o = {`VLANE_NUM{imm_ext}};
         default:               op_b_o = '0;
      endcase
   end

   assign sew_o      = cmd_q.sew;
   assign op_o       = cmd_q.op;
   assign op_valid_o = valid_q;

   // An issued command carries a usable width and source
   assert property (@(posedge clk_i) disable iff (!rst_i)
      op_valid_o |-> sew_o != vlane_pkg::SEW_RSVD
                     && cmd_q.op2_src != vlane_pkg::OP2_RSVD);

endmodule

/* src/result_scatter.sv */
`timescale 1ns/1ps
`include "vlane_settings.svh"

module result_scatter
(
   input  vlane_pkg::lane_vec_t res_i,
   input  vlane_pkg::sew_e      sew_i,
   input  logic                 valid_i,
   output vlane_pkg::lane_vec_t lane_o,
   output logic                 valid_o
);

   //////////////////////////////
   // Result byte placement

   // Lane base+j takes byte j of each ALU in its group
   // Byte positions at G and above repeat the lower G bytes
   always_comb
   begin
      int msk;
      msk = vlane_pkg::grp_mask(sew_i);
      for (int l = 0; l < `VLANE_NUM; l++)
      begin
         for (int p = 0; p < `ELEM_BYTES; p++)
         begin
            lane_o[l].bytes[p] = res_i[(l & ~msk) + (p & msk)].bytes[l & msk];
         end
      end
   end

   assign valid_o = valid_i;  // Scatter adds no delay

endmodule

/* src/vlane_alu_cluster.sv */
`timescale 1ns/1ps
`include "vlane_settings.svh"

module vlane_alu_cluster
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 valid_i,
   input  vlane_pkg::alu_cmd_t  cmd_i,
   input  vlane_pkg::lane_vec_t vs1_i,
   input  vlane_pkg::lane_vec_t vs2_i,
   output logic                 res_valid_o,
   output vlane_pkg::lane_vec_t res_o
);

   //////////////////////////////
   // Stage wires

   vlane_pkg::lane_vec_t                  op_a;
   vlane_pkg::lane_vec_t                  op_b;
   vlane_pkg::sew_e                       op_sew;
   vlane_pkg::alu_op_e                    op_code;
   logic                                  op_valid;
   vlane_pkg::lane_vec_t                  alu_res;
   vlane_pkg::sew_e [`VLANE_NUM-1:0]      alu_sew;
   logic [`VLANE_NUM-1:0]                 alu_valid;

   operand_gather gather_inst
   (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .valid_i    (valid_i),
      .cmd_i      (cmd_i),
      .vs1_i      (vs1_i),
      .vs2_i      (vs2_i),
      .op_a_o     (op_a),
      .op_b_o     (op_b),
      .sew_o      (op_sew),
      .op_o       (op_code),
      .op_valid_o (op_valid)
   );

   generate
      for (genvar i = 0; i < `VLANE_NUM; i++)
      begin : gen_alu
         lane_alu alu_inst
         (
            .clk_i       (clk_i),
            .rst_i       (rst_i),
            .a_i         (op_a[i]),
            .b_i         (op_b[i]),
            .sew_i       (op_sew),
            .op_i        (op_code),
            .valid_i     (op_valid),
            .res_o       (alu_res[i]),
            .sew_o       (alu_sew[i]),
            .res_valid_o (alu_valid[i])
         );
      end
   endgenerate

   // Lane 0 carries sew and valid for the whole cluster
   result_scatter scatter_inst
   (
      .res_i   (alu_res),
      .sew_i   (alu_sew[0]),
      .valid_i (alu_valid[0]),
      .lane_o  (res_o),
      .valid_o (res_valid_o)
   );

endmodule

/* src/vlane_pkg.sv */
`include "vlane_settings.svh"

package vlane_pkg;

   //////////////////////////////
   // Lane data

   // Same word seen whole or per byte
   typedef union packed {
      logic [`ELEM_BYTES*8-1:0]    word;
      logic [`ELEM_BYTES-1:0][7:0] bytes;
   } lane_word_u;

   typedef lane_word_u [`VLANE_NUM-1:0] lane_vec_t;  // 256 bits for 8 lanes

   //////////////////////////////
   // Encodings

   typedef enum logic [1:0] {SEW8 = 2'd0, SEW16 = 2'd1, SEW32 = 2'd2, SEW_RSVD = 2'd3} sew_e;

   typedef enum logic [1:0] {OP2_VEC = 2'd0, OP2_SCALAR = 2'd1, OP2_IMM = 2'd2,
                             OP2_RSVD = 2'd3} op2_src_e;

   typedef enum logic [`OPMODE_W-1:0] {
      ALU_ADD  = 3'd0,
      ALU_SUB  = 3'd1,
      ALU_AND  = 3'd2,
      ALU_OR   = 3'd3,
      ALU_XOR  = 3'd4,
      ALU_MINU = 3'd5,
      ALU_MAXU = 3'd6,
      ALU_RSVD = 3'd7
   } alu_op_e;

   // Command word, 44 bits
   typedef struct packed {
      alu_op_e                  op;
      sew_e                     sew;
      op2_src_e                 op2_src;
      logic [`ELEM_BYTES*8-1:0] scalar;
      logic [`IMM_W-1:0]        imm;
   } alu_cmd_t;

   // Lane group size minus one, works as mask on lane and byte indexes
   function automatic int grp_mask(input sew_e sew);
      int m;
      case (sew)
         SEW16:   m = 1;
         SEW32:   m = 3;
         default: m = 0;  // SEW8 has groups of one lane
      endcase
      return m;
   endfunction

endpackage

/* src/vlane_settings.svh */
`ifndef VLANE_SETTINGS_SVH
`define VLANE_SETTINGS_SVH

// Lanes in the cluster, one ALU per lane
`define VLANE_NUM 8

// Bytes in one lane word
`define ELEM_BYTES 4

// Opcode field width
`define OPMODE_W 3

// Immediate field width, sign extended on use
`define IMM_W 5

`endif

/* verification/vlane_ref_model.svh */
`ifndef VLANE_REF_MODEL_SVH
`define VLANE_REF_MODEL_SVH

`include "vlane_settings.svh"

// Lanes per element group
function automatic int group_lanes(input vlane_pkg::sew_e sew);
   case (sew)
      vlane_pkg::SEW16: return 2;
      vlane_pkg::SEW32: return 4;
      default:          return 1;
   endcase
endfunction

function automatic logic [`ELEM_BYTES*8-1:0] width_mask(input int g);
   case (g)
      2:       return 32'h0000_ffff;
      4:       return 32'hffff_ffff;
      default: return 32'h0000_00ff;
   endcase
endfunction

// Element seen by one ALU, built from byte k of each lane in the group
function automatic vlane_pkg::lane_word_u gather_elem(input vlane_pkg::lane_vec_t v,
                                                      input int alu, input int g);
   vlane_pkg::lane_word_u w;
   int                    base;
   w.word = '0;
   base   = (alu / g) * g;
   for (int j = 0; j < g; j++)
      w.bytes[j] = v[base + j].bytes[alu % g];
   return w;
endfunction

function automatic logic [`ELEM_BYTES*8-1:0] alu_ref(input vlane_pkg::alu_op_e op,
                                                     input logic [`ELEM_BYTES*8-1:0] a,
                                                     input logic [`ELEM_BYTES*8-1:0] b,
                                                     input logic [`ELEM_BYTES*8-1:0] m);
   logic [`ELEM_BYTES*8-1:0] r;
   case (op)
      vlane_pkg::ALU_ADD:  r = (a & m) + (b & m);
      vlane_pkg::ALU_SUB:  r = (a & m) - (b & m);
      vlane_pkg::ALU_AND:  r = a & b;
      vlane_pkg::ALU_OR:   r = a | b;
      vlane_pkg::ALU_XOR:  r = a ^ b;
      vlane_pkg::ALU_MINU: r = ((a & m) <= (b & m)) ? a : b;
      vlane_pkg::ALU_MAXU: r = ((a & m) >= (b & m)) ? a : b;
      default:             r = '0;
   endcase
   return r & m;
endfunction

// Expected res_o for one command
function automatic vlane_pkg::lane_vec_t expected_lanes(input vlane_pkg::alu_cmd_t cmd,
                                                        input vlane_pkg::lane_vec_t v1,
                                                        input vlane_pkg::lane_vec_t v2);
   vlane_pkg::lane_vec_t     alu_out;
   vlane_pkg::lane_vec_t     lanes;
   logic [`ELEM_BYTES*8-1:0] b;
   int                       g;
   int                       imm_val;
   g       = group_lanes(cmd.sew);
   imm_val = $signed(cmd.imm);  // Sign extended into 32 bits
   for (int alu = 0; alu < `VLANE_NUM; alu++)
   begin
      case (cmd.op2_src)
         vlane_pkg::OP2_VEC:    b = gather_elem(v2, alu, g);
         vlane_pkg::OP2_SCALAR: b = cmd.scalar;
         default:               b = imm_val;
      endcase
      alu_out[alu].word = alu_ref(cmd.op, gather_elem(v1, alu, g), b, width_mask(g));
   end
   // Byte p of lane base+j is byte j of ALU base+(p mod g)
   for (int l = 0; l < `VLANE_NUM; l++)
      for (int p = 0; p < `ELEM_BYTES; p++)
         lanes[l].bytes[p] = alu_out[(l / g) * g + (p % g)].bytes[l % g];
   return lanes;
endfunction

`endif

/* verification/vlane_alu_cluster_tb.sv */
`timescale 1ns/1ps
`include "vlane_settings.svh"

module vlane_alu_cluster_tb;

   localparam int CLK_PERIOD  = 20;
   localparam int DRAIN_LIMIT = 50;  // Cycles allowed for the pipeline to empty

   logic                 clk_i;
   logic                 rst_i;
   logic                 valid_i;
   vlane_pkg::alu_cmd_t  cmd_i;
   vlane_pkg::lane_vec_t vs1_i;
   vlane_pkg::lane_vec_t vs2_i;
   logic                 res_valid_o;
   vlane_pkg::lane_vec_t res_o;

   vlane_pkg::lane_vec_t exp_q[$];
   time                  due_q[$];
   vlane_pkg::lane_vec_t mon_exp;
   time                  mon_due;
   int                   error_cnt;
   int                   check_cnt;
   bit                   timed_out;

   `include "vlane_ref_model.svh"

   vlane_alu_cluster UUT
   (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .valid_i     (valid_i),
      .cmd_i       (cmd_i),
      .vs1_i       (vs1_i),
      .vs2_i       (vs2_i),
      .res_valid_o (res_valid_o),
      .res_o       (res_o)
   );

   initial clk_i = 1'b0;
   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   //////////////////////////////
   // Scoreboard, sampled mid-cycle

   always @(negedge clk_i)
   begin
      if (rst_i && res_valid_o !== 1'b0)
      begin
         check_cnt++;
         assert (exp_q.size() > 0)
         else
         begin
            error_cnt++;
            $display("Result valid went high with no command outstanding at %0t", $time);
         end
         if (exp_q.size() > 0)
         begin
            mon_exp = exp_q.pop_front();
            mon_due = due_q.pop_front();
            assert (res_o === mon_exp)
            else
            begin
               error_cnt++;
               $display("FAILED res_o: got %h, expected %h", res_o, mon_exp);
            end
            assert ($time == mon_due)
            else
            begin
               error_cnt++;
               $display("Result arrived at %0t instead of %0t", $time, mon_due);
            end
         end
      end
   end

   //////////////////////////////
   // Stimulus helpers

   task automatic send_cmd(input vlane_pkg::alu_cmd_t cmd, input vlane_pkg::lane_vec_t v1,
                           input vlane_pkg::lane_vec_t v2);
      @(posedge clk_i);
      valid_i <= 1'b1;
      cmd_i   <= cmd;
      vs1_i   <= v1;
      vs2_i   <= v2;
      exp_q.push_back(expected_lanes(cmd, v1, v2));
      due_q.push_back($time + 2 * CLK_PERIOD + CLK_PERIOD / 2);  // Two cycles after the drive
   endtask

   task automatic idle(input int cycles);
      repeat (cycles)
      begin
         @(posedge clk_i);
         valid_i <= 1'b0;
      end
   endtask

   function automatic vlane_pkg::lane_vec_t random_lanes();
      vlane_pkg::lane_vec_t v;
      for (int l = 0; l < `VLANE_NUM; l++)
         v[l].word = $urandom;
      return v;
   endfunction

   function automatic vlane_pkg::alu_cmd_t random_cmd(input vlane_pkg::sew_e sew,
                                                       input vlane_pkg::op2_src_e src);
      vlane_pkg::alu_cmd_t c;
      c.op      = vlane_pkg::alu_op_e'($urandom_range(6, 0));
      c.sew     = sew;
      c.op2_src = src;
      c.scalar  = $urandom;
      c.imm     = $urandom;
      return c;
   endfunction

   task automatic drain_results();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
      begin
         @(posedge clk_i);
         waited++;
      end
      assert (exp_q.size() == 0)
      else
      begin
         error_cnt++;
         timed_out = 1'b1;
         $display("Timed out with %0d results still outstanding", exp_q.size());
      end
   endtask

   //////////////////////////////
   // Tests

   task automatic check_idle_after_reset();
      int err_start;
      err_start = error_cnt;
      repeat (10)
      begin
         @(negedge clk_i);
         check_cnt++;
         assert (res_valid_o === 1'b0)
         else
         begin
            error_cnt++;
            $display("FAILED res_valid_o: got %h, expected 0", res_valid_o);
         end
      end
      $display("Test 1 idle after reset: %0d errors", error_cnt - err_start);
   endtask

   // kind 2 is SEW32 vector, 3 is SEW16/SEW8 vector, 4 is scalar and immediate
   task automatic run_cmd_batch(input int kind, input string name);
      vlane_pkg::alu_cmd_t c;
      int                  err_start;
      err_start = error_cnt;
      for (int i = 0; i < 60; i++)
      begin
         case (kind)
            2:       c = random_cmd(vlane_pkg::SEW32, vlane_pkg::OP2_VEC);
            3:       c = random_cmd((i % 2) ? vlane_pkg::SEW8 : vlane_pkg::SEW16,
                                    vlane_pkg::OP2_VEC);
            default: c = random_cmd(vlane_pkg::sew_e'(i % 3),
                                    (i % 2) ? vlane_pkg::OP2_IMM : vlane_pkg::OP2_SCALAR);
         endcase
         if (kind == 2)
            c.op = vlane_pkg::alu_op_e'(i % 7);  // Walk all seven ops
         if (i % 4 == 1)
            c.imm[`IMM_W-1] = 1'b1;  // Negative immediate
         send_cmd(c, random_lanes(), random_lanes());
      end
      idle(1);
      drain_results();
      $display("Test %0d %s: %0d errors", kind, name, error_cnt - err_start);
   endtask

   task automatic stream_random_cmds();
      vlane_pkg::alu_cmd_t c;
      int                  err_start;
      err_start = error_cnt;
      for (int i = 0; i < 200; i++)
      begin
         c = random_cmd(vlane_pkg::sew_e'($urandom_range(2, 0)),
                        vlane_pkg::op2_src_e'($urandom_range(2, 0)));
         send_cmd(c, random_lanes(), random_lanes());
         idle($urandom_range(3, 0));
      end
      idle(1);
      drain_results();
      $display("Test 5 random stream with gaps: %0d errors", error_cnt - err_start);
   endtask

   initial
   begin
      void'($urandom(32'h795e_960c));
      error_cnt = 0;
      check_cnt = 0;
      timed_out = 1'b0;
      rst_i     = 1'b0;
      valid_i   = 1'b0;
      cmd_i     = '0;
      vs1_i     = '0;
      vs2_i     = '0;
      repeat (3) @(posedge clk_i);
      rst_i <= 1'b1;

      check_idle_after_reset();
      if (!timed_out)
         run_cmd_batch(2, "SEW32 vector regrouping");
      if (!timed_out)
         run_cmd_batch(3, "SEW16 and SEW8 vector");
      if (!timed_out)
         run_cmd_batch(4, "scalar and immediate operands");
      if (!timed_out)
         stream_random_cmds();

      $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
      if (error_cnt == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

/* verilog.f */
+incdir+src
+incdir+verification
src/vlane_pkg.sv
src/operand_gather.sv
src/lane_alu.sv
src/result_scatter.sv
src/vlane_alu_cluster.sv
verification/vlane_alu_cluster_tb.sv
